//--- rtl/game_cfg.svh
// match format constants for the penalty shoot-out scoring core
// include wherever round length, winning score or report marker is needed

`ifndef GAME_CFG_SVH
`define GAME_CFG_SVH

// clock cycles the keeper has in one round
`define ROUND_CYCLES 8

// first side to reach this score takes the match
`define WIN_SCORE 5

// fixed marker in the low bits of every report byte
`define REPORT_TAG 3'b111

`endif

//--- rtl/game_pkg.sv
// shared types of the penalty shoot-out scoring core
// referenced by scoped names from the fsm, score controller, link and top

package game_pkg;

    typedef logic [2:0] score_t;   // score of one side
    typedef logic [1:0] dir_t;     // left / centre / right

    // {1'b0, is_scored, player score, tag}
    typedef logic [7:0] report_t;

    // match state
    typedef enum logic [1:0] {
        IDLE,
        KEEPER,
        REPORT,
        OVER
    } g_state;

endpackage

//--- rtl/game_fsm.sv
// match state machine of the penalty shoot-out
// runs keeper rounds, decides goal or save when the round timer expires
// and holds the next round until the score report has left the link

`timescale 1ns/1ps

module game_fsm (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  game_pkg::dir_t    shot_dir,
    input  game_pkg::dir_t    dive_dir,
    input  logic              timer_expired,
    input  logic              match_end,
    input  logic              link_busy,
    output game_pkg::g_state  game_state,
    output logic              timer_load,
    output logic              round_done,
    output logic              is_scored
);

    // report entry -> score update -> match_end registered
    localparam logic [1:0] SETTLE_CYCLES = 2'd2;

    logic [1:0] settle_cnt;
    logic       settled;
    logic       report_exit;

    assign settled     = (settle_cnt == SETTLE_CYCLES);
    assign report_exit = (game_state == game_pkg::REPORT) && settled && !link_busy;

    // load the timer on the same cycle the fsm heads into KEEPER
    assign timer_load = ((game_state == game_pkg::IDLE) && start) ||
                        (report_exit && !match_end);

    always_ff @(posedge clk) begin
        if (rst) begin
            game_state <= game_pkg::IDLE;
            round_done <= 1'b0;
            settle_cnt <= '0;
        end else begin
            round_done <= 1'b0;  // one pulse per round
            case (game_state)
                game_pkg::IDLE: begin
                    if (start)
                        game_state <= game_pkg::KEEPER;
                end
                game_pkg::KEEPER: begin
                    if (timer_expired) begin
                        round_done <= 1'b1;
                        settle_cnt <= '0;
                        game_state <= game_pkg::REPORT;
                    end
                end
                game_pkg::REPORT: begin
                    if (!settled)
                        settle_cnt <= settle_cnt + 2'd1;
                    else if (!link_busy)
                        game_state <= match_end ? game_pkg::OVER : game_pkg::KEEPER;
                end
                default: begin  // OVER
                    if (start)
                        game_state <= game_pkg::IDLE;
                end
            endcase
        end
    end

    // goal when the keeper dived the wrong way
    always_ff @(posedge clk) begin
        if (game_state == game_pkg::KEEPER && timer_expired)
            is_scored <= (shot_dir != dive_dir);
    end

endmodule

//--- rtl/round_timer.sv
// round length counter for the keeper phase
// load starts (or restarts) a count of ROUND_CYCLES, expired pulses once at the end

`timescale 1ns/1ps

`include "game_cfg.svh"

module round_timer (
    input  logic clk,
    input  logic rst,
    input  logic load,
    output logic expired
);

    localparam int CNT_W = $clog2(`ROUND_CYCLES + 1);

    logic [CNT_W-1:0] cnt;  // zero means idle

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt     <= '0;
            expired <= 1'b0;
        end else begin
            expired <= 1'b0;
            if (load) begin
                cnt <= CNT_W'(`ROUND_CYCLES);
            end else if (cnt != '0) begin
                cnt <= cnt - CNT_W'(1);
                if (cnt == CNT_W'(1))
                    expired <= 1'b1;  // last count of the round
            end
        end
    end

endmodule

//--- rtl/score_control.sv
// score keeping for both sides of the shoot-out
// updates on each finished round, flags the match end and winner
// and hands a fresh report byte to the link transmitter

`timescale 1ns/1ps

`include "game_cfg.svh"

module score_control (
    input  logic              clk,
    input  logic              rst,
    input  game_pkg::g_state  game_state,
    input  logic              round_done,
    input  logic              is_scored,
    output game_pkg::score_t  score_player,
    output game_pkg::score_t  score_enemy,
    output logic              match_end,
    output logic              match_result,
    output logic              report_load,
    output game_pkg::report_t report_data
);

    game_pkg::score_t score_player_nxt;
    game_pkg::score_t score_enemy_nxt;
    logic             score_upd;
    logic             player_won;
    logic             enemy_won;

    assign score_upd = (game_state == game_pkg::REPORT) && round_done;

    always_comb begin
        score_player_nxt = score_player;
        score_enemy_nxt  = score_enemy;
        if (game_state == game_pkg::IDLE) begin
            // fresh match, final score stays up in OVER
            score_player_nxt = '0;
            score_enemy_nxt  = '0;
        end else if (score_upd) begin
            if (is_scored)
                score_enemy_nxt = score_enemy + 3'd1;    // goal
            else
                score_player_nxt = score_player + 3'd1;  // save
        end
    end

    assign player_won = (score_player == game_pkg::score_t'(`WIN_SCORE));
    assign enemy_won  = (score_enemy == game_pkg::score_t'(`WIN_SCORE));

    always_ff @(posedge clk) begin
        if (rst) begin
            score_player <= '0;
            score_enemy  <= '0;
            match_end    <= 1'b0;
            match_result <= 1'b0;
            report_load  <= 1'b0;
        end else begin
            score_player <= score_player_nxt;
            score_enemy  <= score_enemy_nxt;
            match_end    <= player_won || enemy_won;  // one cycle behind the scores
            match_result <= player_won;
            report_load  <= score_upd;
        end
    end

    // report carries the player score after this round
    always_ff @(posedge clk) begin
        if (score_upd)
            report_data <= {1'b0, is_scored, score_player_nxt, `REPORT_TAG};
    end

endmodule

//--- rtl/score_link_tx.sv
// four-phase req/ack sender for the score report
// holds one byte from load until the far side has acked and released ack
// busy stays high for the whole exchange

`timescale 1ns/1ps

module score_link_tx (
    input  logic              clk,
    input  logic              rst,
    input  logic              load,
    input  game_pkg::report_t data,
    input  logic              ack,
    output logic              req,
    output game_pkg::report_t link_data,
    output logic              busy
);

    typedef enum logic [1:0] {
        LINK_IDLE,
        LINK_REQ,
        LINK_RELEASE
    } link_phase_t;

    link_phase_t phase;

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= LINK_IDLE;
        end else begin
            case (phase)
                LINK_IDLE: begin
                    if (load)
                        phase <= LINK_REQ;
                end
                LINK_REQ: begin
                    if (ack)
                        phase <= LINK_RELEASE;  // far side has the byte
                end
                LINK_RELEASE: begin
                    if (!ack)
                        phase <= LINK_IDLE;
                end
                default: phase <= LINK_IDLE;
            endcase
        end
    end

    // byte is frozen until the next load in idle
    always_ff @(posedge clk) begin
        if (phase == LINK_IDLE && load)
            link_data <= data;
    end

    assign req  = (phase == LINK_REQ);
    assign busy = (phase != LINK_IDLE);

endmodule

//--- rtl/penalty_top.sv
// top of the penalty shoot-out scoring core
// connects the match fsm, round timer, score controller and report link
// shot_dir and dive_dir must stay stable while a round runs

`timescale 1ns/1ps

module penalty_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  game_pkg::dir_t    shot_dir,
    input  game_pkg::dir_t    dive_dir,
    input  logic              link_ack,
    output game_pkg::g_state  game_state,
    output game_pkg::score_t  score_player,
    output game_pkg::score_t  score_enemy,
    output logic              match_end,
    output logic              match_result,
    output logic              link_req,
    output game_pkg::report_t link_data
);

    logic              timer_load;
    logic              timer_expired;
    logic              round_done;
    logic              is_scored;
    logic              report_load;
    game_pkg::report_t report_data;
    logic              link_busy;

    game_fsm fsm_inst (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .shot_dir      (shot_dir),
        .dive_dir      (dive_dir),
        .timer_expired (timer_expired),
        .match_end     (match_end),
        .link_busy     (link_busy),
        .game_state    (game_state),
        .timer_load    (timer_load),
        .round_done    (round_done),
        .is_scored     (is_scored)
    );

    round_timer timer_inst (
        .clk     (clk),
        .rst     (rst),
        .load    (timer_load),
        .expired (timer_expired)
    );

    score_control score_inst (
        .clk          (clk),
        .rst          (rst),
        .game_state   (game_state),
        .round_done   (round_done),
        .is_scored    (is_scored),
        .score_player (score_player),
        .score_enemy  (score_enemy),
        .match_end    (match_end),
        .match_result (match_result),
        .report_load  (report_load),
        .report_data  (report_data)
    );

    score_link_tx link_inst (
        .clk       (clk),
        .rst       (rst),
        .load      (report_load),
        .data      (report_data),
        .ack       (link_ack),
        .req       (link_req),
        .link_data (link_data),
        .busy      (link_busy)
    );

endmodule

//--- dv/penalty_tb.sv
// directed testbench for the penalty shoot-out scoring core
// plays keeper rounds against a remote ack model, checks scores,
// report bytes, the req/ack handshake and both ways a match can end

`timescale 1ns/1ps

`include "game_cfg.svh"

module penalty_tb;

    localparam int MAX_ACK_DELAY = 6;
    localparam int MAX_ROUNDS    = 30;
    // each round runs the timer, decision and settle, then both ack phases
    localparam int TIMEOUT_CYCLES =
        MAX_ROUNDS * (`ROUND_CYCLES + 6 + 2 * (MAX_ACK_DELAY + 1)) + 200;

    logic              clk = 1'b0;
    logic              rst;
    logic              start;
    game_pkg::dir_t    shot_dir;
    game_pkg::dir_t    dive_dir;
    logic              link_ack;
    game_pkg::g_state  game_state;
    game_pkg::score_t  score_player;
    game_pkg::score_t  score_enemy;
    logic              match_end;
    logic              match_result;
    logic              link_req;
    game_pkg::report_t link_data;

    int                ack_delay = 0;  // cycles the far side takes per phase
    game_pkg::report_t rx_q[$];        // bytes taken by the far side
    logic [31:0]       lcg_state = 32'd30485;
    int                cycle_cnt = 0;
    int                check_cnt = 0;
    int                err_cnt = 0;
    game_pkg::score_t  exp_player;
    game_pkg::score_t  exp_enemy;
    logic              match_over;

    penalty_top penalty_inst (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .shot_dir     (shot_dir),
        .dive_dir     (dive_dir),
        .link_ack     (link_ack),
        .game_state   (game_state),
        .score_player (score_player),
        .score_enemy  (score_enemy),
        .match_end    (match_end),
        .match_result (match_result),
        .link_req     (link_req),
        .link_data    (link_data)
    );

    always #2 clk = ~clk;  // 4 ns period

    // far side of the link answers each phase after ack_delay cycles
    initial begin
        int ack_wait;
        ack_wait = 0;
        link_ack <= 1'b0;
        forever begin
            @(negedge clk);
            if (rst) begin
                link_ack <= 1'b0;
                ack_wait = 0;
            end else if (link_req != link_ack) begin
                if (ack_wait >= ack_delay) begin
                    if (link_req)
                        rx_q.push_back(link_data);
                    link_ack <= link_req;
                    ack_wait = 0;
                end else begin
                    ack_wait++;
                end
            end
        end
    end

    // a new request must wait for the old ack to drop
    initial begin
        logic req_prev;
        req_prev = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst && link_req && !req_prev && link_ack) begin
                $display("FAILED %0t link_req rose while link_ack was still high", $time);
                err_cnt++;
            end
            req_prev = link_req;
        end
    end

    initial begin
        while (cycle_cnt <= TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, the DUT stopped making progress", cycle_cnt);
        $display("Errors found");
        $finish;
    end

    function automatic game_pkg::dir_t rand_dir();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return game_pkg::dir_t'((lcg_state >> 16) % 32'd3);  // left, centre or right
    endfunction

    task automatic check_score(input string name, input game_pkg::score_t act,
                               input game_pkg::score_t exp);
        check_cnt++;
        if (act !== exp) begin
            $display("FAILED %0t %s: expected %0d, got %0d", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_report(input string name, input game_pkg::report_t act,
                                input game_pkg::report_t exp);
        check_cnt++;
        if (act !== exp) begin
            $display("FAILED %0t %s: expected %h, got %h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_state(input string name, input game_pkg::g_state act,
                               input game_pkg::g_state exp);
        check_cnt++;
        if (act !== exp) begin
            $display("FAILED %0t %s: expected %s, got %s", $time, name, exp.name(),
                     act.name());
            err_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        check_cnt++;
        if (act !== exp) begin
            $display("FAILED %0t %s: expected %b, got %b", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic reset_dut();
        @(negedge clk);
        rst = 1'b1;
        start = 1'b0;
        shot_dir = '0;
        dive_dir = '0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        rx_q.delete();
        exp_player = '0;
        exp_enemy = '0;
        match_over = 1'b0;
    endtask

    task automatic pulse_start();
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("test %-14s done, %0d new errors", name, err_cnt - errs_before);
    endtask

    // plays one keeper round starting from a falling edge in KEEPER
    task automatic play_round(input game_pkg::dir_t shot, input game_pkg::dir_t dive);
        int                report_cycles;
        logic              scored;
        game_pkg::report_t rx_byte;
        report_cycles = 0;
        check_state("game_state", game_state, game_pkg::KEEPER);
        shot_dir = shot;  // held until the next round
        dive_dir = dive;
        while (game_state != game_pkg::REPORT)
            @(negedge clk);
        while (game_state == game_pkg::REPORT) begin
            @(negedge clk);
            report_cycles++;
        end
        scored = (shot != dive);  // wrong dive lets the goal in
        if (scored)
            exp_enemy = exp_enemy + 3'd1;
        else
            exp_player = exp_player + 3'd1;
        match_over = (exp_player == game_pkg::score_t'(`WIN_SCORE)) ||
                     (exp_enemy == game_pkg::score_t'(`WIN_SCORE));
        // both ack phases had to pass before the round ended
        check_bit("report_held", report_cycles >= 2 * (ack_delay + 1), 1'b1);
        check_bit("link_ack", link_ack, 1'b0);
        check_bit("link_req", link_req, 1'b0);
        if (rx_q.size() != 1) begin
            $display("expected one report byte for the round but %0d arrived", rx_q.size());
            err_cnt++;
            rx_q.delete();
        end else begin
            rx_byte = rx_q.pop_front();
            check_report("link_data", rx_byte, {1'b0, scored, exp_player, `REPORT_TAG});
        end
        check_score("score_player", score_player, exp_player);
        check_score("score_enemy", score_enemy, exp_enemy);
        check_bit("match_end", match_end, match_over);
        if (match_over) begin
            check_state("game_state", game_state, game_pkg::OVER);
            check_bit("match_result", match_result,
                      exp_player == game_pkg::score_t'(`WIN_SCORE));
        end else begin
            check_state("game_state", game_state, game_pkg::KEEPER);
        end
    endtask

    task automatic test_reset();
        int errs_before;
        errs_before = err_cnt;
        ack_delay = 0;
        reset_dut();
        check_state("game_state", game_state, game_pkg::IDLE);
        check_score("score_player", score_player, '0);
        check_score("score_enemy", score_enemy, '0);
        check_bit("match_end", match_end, 1'b0);
        check_bit("link_req", link_req, 1'b0);
        pulse_start();
        check_state("game_state", game_state, game_pkg::KEEPER);
        report_test("reset_state", errs_before);
    endtask

    task automatic test_random_rounds();
        int             errs_before;
        game_pkg::dir_t shot;
        game_pkg::dir_t dive;
        errs_before = err_cnt;
        ack_delay = 1;
        reset_dut();
        pulse_start();
        for (int i = 0; i < 9 && !match_over; i++) begin
            shot = rand_dir();
            dive = rand_dir();
            play_round(shot, dive);
        end
        report_test("random_rounds", errs_before);
    endtask

    task automatic test_back_pressure();
        int             errs_before;
        game_pkg::dir_t shot;
        game_pkg::dir_t dive;
        errs_before = err_cnt;
        ack_delay = MAX_ACK_DELAY;  // slow far side
        reset_dut();
        pulse_start();
        for (int i = 0; i < 4; i++) begin
            shot = rand_dir();
            dive = rand_dir();
            play_round(shot, dive);
        end
        report_test("back_pressure", errs_before);
    endtask

    task automatic test_player_win();
        int             errs_before;
        game_pkg::dir_t dir;
        errs_before = err_cnt;
        ack_delay = 2;
        reset_dut();
        pulse_start();
        for (int i = 0; i < `WIN_SCORE; i++) begin
            dir = rand_dir();
            play_round(dir, dir);  // keeper guesses right every time
        end
        check_score("score_player", score_player, game_pkg::score_t'(`WIN_SCORE));
        check_score("score_enemy", score_enemy, '0);
        repeat (4) @(negedge clk);
        // final score stays up in OVER
        check_state("game_state", game_state, game_pkg::OVER);
        check_score("score_player", score_player, game_pkg::score_t'(`WIN_SCORE));
        check_score("score_enemy", score_enemy, '0);
        check_bit("match_result", match_result, 1'b1);
        report_test("player_win", errs_before);
    endtask

    task automatic test_enemy_win();
        int             errs_before;
        game_pkg::dir_t dir;
        errs_before = err_cnt;
        ack_delay = 0;
        reset_dut();
        pulse_start();
        for (int i = 0; i < `WIN_SCORE; i++) begin
            dir = rand_dir();
            play_round(dir, (dir == 2'd2) ? 2'd0 : dir + 2'd1);  // always the wrong way
        end
        check_bit("match_end", match_end, 1'b1);
        check_bit("match_result", match_result, 1'b0);
        check_score("score_enemy", score_enemy, game_pkg::score_t'(`WIN_SCORE));
        pulse_start();
        check_state("game_state", game_state, game_pkg::IDLE);
        repeat (2) @(negedge clk);  // scores clear, then match_end follows
        check_score("score_player", score_player, '0);
        check_score("score_enemy", score_enemy, '0);
        check_bit("match_end", match_end, 1'b0);
        report_test("enemy_win", errs_before);
    endtask

    initial begin
        rst = 1'b1;
        start = 1'b0;
        shot_dir = '0;
        dive_dir = '0;
        test_reset();
        test_random_rounds();
        test_back_pressure();
        test_player_win();
        test_enemy_win();
        $display("%0d checks, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

//--- build.f
+incdir+rtl
rtl/game_pkg.sv
rtl/game_fsm.sv
rtl/round_timer.sv
rtl/score_control.sv
rtl/score_link_tx.sv
rtl/penalty_top.sv
dv/penalty_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the penalty shoot-out testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    -f build.f \
    --top-module penalty_tb \
    -o penalty_sim

sim_out=$(./obj_dir/penalty_sim)
echo "$sim_out"

if echo "$sim_out" | grep -q "^No errors$"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
